//--- project.f
+incdir+design
design/sdram_pkg.sv
design/sdram_refresh_timer.sv
design/sdram_bank_tracker.sv
design/sdram_seq_fsm.sv
design/sdram_cmd_gen.sv
design/sdram_rd_path.sv
design/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/tb_sdram_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_sdram_ctrl \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0

//--- tb/tb_sdram_ctrl.sv
// Needs about 5100 cycles of power-up before the first access; all checks stop at the first error
`include "sdram_cfg.svh"
`default_nettype none

module tb_sdram_ctrl;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int op_write = 0;
  localparam int op_read = 1;
  localparam int op_wait = 2;
  localparam int max_entries = 48;
  localparam int refresh_gap = 400;

  logic        clk_i;
  logic        rst_i;
  logic [3:0]  wr_i;
  logic        rd_i;
  logic [25:0] addr_i;
  logic [31:0] wdata_i;
  logic        accept_o;
  logic        ack_o;
  logic [31:0] rdata_o;
  logic        sdram_clk, sdram_cke, sdram_cs, sdram_ras, sdram_cas, sdram_we, sdram_oe;
  logic [3:0]  sdram_dqm;
  logic [12:0] sdram_addr;
  logic [1:0]  sdram_ba;
  logic [31:0] sdram_dq_out;
  logic [31:0] sdram_dq_in;
  logic        model_fault;
  int          model_refreshes;

  // Operation table
  int          op_tab [max_entries];
  logic [25:0] addr_tab [max_entries];
  logic [3:0]  mask_tab [max_entries];
  logic [31:0] data_tab [max_entries];
  logic [31:0] exp_tab [max_entries];
  int          n_entries = 0;
  logic [31:0] ref_mem [logic [25:0]];

  int          seed = 27;
  int          cyc = 0;
  int          cycle_limit = 5200;
  int          init_seen = 0;
  int          last_refresh_cyc = 0;
  int          seen_refreshes = 0;

  // Outstanding accesses, oldest first
  int          due_q [$];
  logic        is_read_q [$];
  logic [31:0] exp_q [$];

  sdram_ctrl_top uut (
    .clk_i (clk_i), .rst_i (rst_i),
    .wr_i (wr_i), .rd_i (rd_i), .addr_i (addr_i), .wdata_i (wdata_i),
    .accept_o (accept_o), .ack_o (ack_o), .rdata_o (rdata_o),
    .sdram_clk_o (sdram_clk), .sdram_cke_o (sdram_cke),
    .sdram_cs_o (sdram_cs), .sdram_ras_o (sdram_ras),
    .sdram_cas_o (sdram_cas), .sdram_we_o (sdram_we),
    .sdram_dqm_o (sdram_dqm), .sdram_addr_o (sdram_addr), .sdram_ba_o (sdram_ba),
    .sdram_dq_o (sdram_dq_out), .sdram_dq_oe_o (sdram_oe), .sdram_dq_i (sdram_dq_in)
  );

  sdram_model u_model (
    .clk_i (sdram_clk), .cke_i (sdram_cke),
    .cs_i (sdram_cs), .ras_i (sdram_ras), .cas_i (sdram_cas), .we_i (sdram_we),
    .ba_i (sdram_ba), .addr_i (sdram_addr), .dqm_i (sdram_dqm),
    .dq_i (sdram_dq_out), .dq_oe_i (sdram_oe), .dq_o (sdram_dq_in),
    .fault_o (model_fault), .refresh_count_o (model_refreshes)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [25:0] make_addr(input int row, input int bank, input int col);
    return {row[12:0], bank[1:0], col[8:0], 2'b00};
  endfunction

  // Byte lanes with a set enable take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic add_entry(input int op, input logic [25:0] addr, input logic [3:0] mask,
                           input logic [31:0] data);
    logic [31:0] old_word;
    op_tab[n_entries]   = op;
    addr_tab[n_entries] = addr;
    mask_tab[n_entries] = mask;
    data_tab[n_entries] = data;
    exp_tab[n_entries]  = 32'h0;
    if (op == op_write) begin
      old_word = ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
      ref_mem[addr] = merge_bytes(old_word, data, mask);
    end else if (op == op_read) begin
      exp_tab[n_entries] = ref_mem[addr];
    end
    n_entries++;
  endtask

  task automatic add_write(input logic [25:0] addr, input logic [3:0] mask);
    add_entry(op_write, addr, mask, $random(seed));
  endtask

  task automatic add_read(input logic [25:0] addr);
    add_entry(op_read, addr, 4'b0, 32'h0);
  endtask

  task automatic build_table();
    // Write then read back
    add_write(make_addr(0, 0, 5), 4'b1111);
    add_read(make_addr(0, 0, 5));
    // Byte masks
    add_write(make_addr(0, 0, 9), 4'b1111);
    add_write(make_addr(0, 0, 9), 4'b0001);
    add_write(make_addr(0, 0, 9), 4'b1100);
    add_read(make_addr(0, 0, 9));
    // Back-to-back on the open row
    add_write(make_addr(0, 0, 10), 4'b1111);
    add_write(make_addr(0, 0, 11), 4'b1111);
    add_read(make_addr(0, 0, 10));
    add_read(make_addr(0, 0, 11));
    // Row misses in bank 0
    add_write(make_addr(7, 0, 5), 4'b1111);
    add_read(make_addr(7, 0, 5));
    add_read(make_addr(0, 0, 5));
    add_read(make_addr(7, 0, 5));
    // Other banks
    add_write(make_addr(3, 1, 1), 4'b1111);
    add_write(make_addr(100, 2, 2), 4'b1111);
    add_write(make_addr(8191, 3, 511), 4'b1111);
    add_read(make_addr(3, 1, 1));
    add_read(make_addr(100, 2, 2));
    add_read(make_addr(8191, 3, 511));
    add_read(make_addr(0, 0, 5));
    // Idle long enough for a periodic refresh
    add_write(make_addr(2, 2, 3), 4'b1111);
    for (int k = 0; k < 12; k++) begin
      add_entry(op_wait, 26'h0, 4'b0, 32'd35);
    end
    add_read(make_addr(2, 2, 3));
    add_read(make_addr(0, 0, 9));
    add_read(make_addr(3, 1, 1));
  endtask

  // --------------------------------------------------
  // Cycle count and timeout
  // --------------------------------------------------
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  always @(negedge clk_i) begin
    if (model_fault) begin
      abort_run("The SDRAM model reported a protocol violation");
    end
  end

  // Reset state, power-up command order, then refresh spacing
  always @(negedge clk_i) begin
    if (rst_i) begin
      check_value("sdram_cke_o", 32'(sdram_cke), 32'd0);
      check_value("accept_o", 32'(accept_o), 32'd0);
      check_value("ack_o", 32'(ack_o), 32'd0);
      check_value("sdram command", 32'({sdram_cs, sdram_ras, sdram_cas, sdram_we}),
                  32'h7);
      check_value("sdram_dq_oe_o", 32'(sdram_oe), 32'd0);
    end else if (init_seen < 4) begin
      check_value("accept_o", 32'(accept_o), 32'd0);
      check_value("ack_o", 32'(ack_o), 32'd0);
      check_value("sdram_dq_oe_o", 32'(sdram_oe), 32'd0);
      if ({sdram_cs, sdram_ras, sdram_cas, sdram_we} != 4'b0111) begin
        check_value("sdram_cke_o", 32'(sdram_cke), 32'd1);
        case (init_seen)
          0: begin
            check_value("init command", 32'({sdram_cs, sdram_ras, sdram_cas, sdram_we}),
                        32'h2);
            check_value("sdram_addr_o[10]", 32'(sdram_addr[10]), 32'd1);
          end
          1, 2: begin
            check_value("init command", 32'({sdram_cs, sdram_ras, sdram_cas, sdram_we}),
                        32'h1);
          end
          default: begin
            check_value("init command", 32'({sdram_cs, sdram_ras, sdram_cas, sdram_we}),
                        32'h0);
            check_value("sdram_addr_o", 32'(sdram_addr), 32'(`SDRAM_MODE_REG));
            last_refresh_cyc = cyc;
            seen_refreshes   = model_refreshes;
          end
        endcase
        init_seen++;
      end
    end else if (model_refreshes != seen_refreshes) begin
      // New refresh seen by the model
      seen_refreshes   = model_refreshes;
      last_refresh_cyc = cyc;
    end else if (cyc - last_refresh_cyc > refresh_gap) begin
      abort_run("No auto-refresh command within 400 cycles after power-up");
    end
  end

  // Ack timing and read data against the outstanding queue
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (ack_o) begin
        if (due_q.size() == 0) begin
          abort_run("ack_o pulsed with no access outstanding");
        end else begin
          check_value("ack_o cycle", cyc, due_q[0]);
          if (is_read_q[0]) check_value("rdata_o", rdata_o, exp_q[0]);
          void'(due_q.pop_front());
          void'(is_read_q.pop_front());
          void'(exp_q.pop_front());
        end
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        abort_run("ack_o missing for an accepted access");
      end
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    rst_i   = 1'b1;
    rd_i    = 1'b0;
    wr_i    = 4'b0;
    addr_i  = 26'h0;
    wdata_i = 32'h0;
    build_table();
    cycle_limit = 5200 + 40 * n_entries;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      @(negedge clk_i);
      if (op_tab[i] == op_wait) begin
        rd_i = 1'b0;
        wr_i = 4'b0;
        repeat (data_tab[i]) @(negedge clk_i);
      end else begin
        addr_i  = addr_tab[i];
        wdata_i = data_tab[i];
        rd_i    = (op_tab[i] == op_read);
        wr_i    = (op_tab[i] == op_write) ? mask_tab[i] : 4'b0;
        // Hold the request through the accept cycle
        do @(negedge clk_i); while (!accept_o);
        due_q.push_back(cyc + ((op_tab[i] == op_read) ? 3 : 2));
        is_read_q.push_back(op_tab[i] == op_read);
        exp_q.push_back(exp_tab[i]);
      end
    end
    @(negedge clk_i);
    rd_i = 1'b0;
    wr_i = 4'b0;
    while (due_q.size() != 0) @(negedge clk_i);
    repeat (5) @(negedge clk_i);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/sdram_model.sv
// Behavioral SDR SDRAM, single-word bursts only; read data is registered on the SDRAM clock edge
`include "sdram_cfg.svh"
`default_nettype none

module sdram_model (
  input  wire                      clk_i,
  input  wire                      cke_i,
  input  wire                      cs_i,
  input  wire                      ras_i,
  input  wire                      cas_i,
  input  wire                      we_i,
  input  wire [`SDRAM_BANK_W-1:0]  ba_i,
  input  wire [`SDRAM_ROW_W-1:0]   addr_i,
  input  wire [`SDRAM_DQM_W-1:0]   dqm_i,
  input  wire [`SDRAM_DATA_W-1:0]  dq_i,
  input  wire                      dq_oe_i,
  output logic [`SDRAM_DATA_W-1:0] dq_o,
  output logic                     fault_o,
  output int                       refresh_count_o
);
  timeunit 1ns;
  timeprecision 1ns;

  // Sparse word memory keyed by bank, row and column
  logic [31:0] mem [logic [23:0]];
  logic [3:0]  open_q = 4'b0;
  logic [12:0] row_q [4];
  logic [31:0] dq_q = 32'h0;
  logic        fault_q = 1'b0;
  int          refresh_q = 0;
  logic [3:0]  cmd;

  assign cmd             = {cs_i, ras_i, cas_i, we_i};
  assign dq_o            = dq_q;
  assign fault_o         = fault_q;
  assign refresh_count_o = refresh_q;

  // Unwritten words read back an address-derived pattern
  function automatic logic [31:0] read_word(input logic [23:0] key);
    if (mem.exists(key)) begin
      return mem[key];
    end
    return {key[7:0], key};
  endfunction

  task automatic report_fault(input string msg);
    $display("SDRAM model: %s", msg);
    fault_q <= 1'b1;
  endtask

  // --------------------------------------------------
  // Command decode, mid-cycle of the controller clock
  // --------------------------------------------------
  always @(posedge clk_i) begin
    logic [23:0] key;
    logic [31:0] word;
    key = {ba_i, row_q[ba_i], addr_i[8:0]};
    dq_q <= 32'h0;
    if (cke_i) begin
      case (cmd)
        4'b0011: begin
          if (open_q[ba_i]) report_fault("ACTIVE issued to a bank that is already open");
          open_q[ba_i] <= 1'b1;
          row_q[ba_i]  <= addr_i;
        end
        4'b0101: begin
          if (!open_q[ba_i]) begin
            report_fault("READ issued to a closed bank");
          end else begin
            dq_q <= read_word(key);
          end
        end
        4'b0100: begin
          if (!open_q[ba_i] || !dq_oe_i) begin
            report_fault("WRITE issued to a closed bank or without data drive");
          end else begin
            word = read_word(key);
            // DQM high keeps the stored byte
            for (int b = 0; b < 4; b++) begin
              if (!dqm_i[b]) word[8*b +: 8] = dq_i[8*b +: 8];
            end
            mem[key] = word;
          end
        end
        4'b0010: begin
          if (addr_i[`SDRAM_AP_BIT]) open_q <= 4'b0;
          else open_q[ba_i] <= 1'b0;
        end
        4'b0001: begin
          if (|open_q) report_fault("REFRESH issued while a bank is open");
          refresh_q <= refresh_q + 1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/sdram_ctrl_top.sv
// Host holds a request until accept_o; one ack_o pulse per word, no error reporting
`include "sdram_cfg.svh"
`default_nettype none

module sdram_ctrl_top
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  // Host side
  input  wire [`SDRAM_DQM_W-1:0]   wr_i,
  input  wire                      rd_i,
  input  wire [`SDRAM_HADDR_W-1:0] addr_i,
  input  wire [`SDRAM_DATA_W-1:0]  wdata_i,
  output logic                     accept_o,
  output logic                     ack_o,
  output logic [`SDRAM_DATA_W-1:0] rdata_o,
  // SDRAM side
  output logic                     sdram_clk_o,
  output logic                     sdram_cke_o,
  output logic                     sdram_cs_o,
  output logic                     sdram_ras_o,
  output logic                     sdram_cas_o,
  output logic                     sdram_we_o,
  output logic [`SDRAM_DQM_W-1:0]  sdram_dqm_o,
  output logic [`SDRAM_ROW_W-1:0]  sdram_addr_o,
  output logic [`SDRAM_BANK_W-1:0] sdram_ba_o,
  output logic [`SDRAM_DATA_W-1:0] sdram_dq_o,
  output logic                     sdram_dq_oe_o,
  input  wire [`SDRAM_DATA_W-1:0]  sdram_dq_i
);

  sdram_state_e     state;
  sdram_init_step_e init_step;
  logic             precharge_all;
  logic             refresh_pending;
  logic             row_hit;
  logic             bank_open;
  logic             any_open;

  // Inverted clock centres commands on the SDRAM rising edge
  assign sdram_clk_o = ~clk_i;

  sdram_refresh_timer u_timer (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .state_i           (state),
    .refresh_pending_o (refresh_pending),
    .init_step_o       (init_step)
  );

  sdram_bank_tracker u_tracker (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .state_i         (state),
    .precharge_all_i (precharge_all),
    .addr_i          (addr_i),
    .row_hit_o       (row_hit),
    .bank_open_o     (bank_open),
    .any_open_o      (any_open)
  );

  sdram_seq_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .rd_i              (rd_i),
    .wr_i              (wr_i),
    .refresh_pending_i (refresh_pending),
    .row_hit_i         (row_hit),
    .bank_open_i       (bank_open),
    .any_open_i        (any_open),
    .state_o           (state),
    .precharge_all_o   (precharge_all),
    .accept_o          (accept_o)
  );

  sdram_cmd_gen u_cmd (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .state_i         (state),
    .precharge_all_i (precharge_all),
    .init_step_i     (init_step),
    .addr_i          (addr_i),
    .wr_i            (wr_i),
    .wdata_i         (wdata_i),
    .sdram_cke_o     (sdram_cke_o),
    .sdram_cs_o      (sdram_cs_o),
    .sdram_ras_o     (sdram_ras_o),
    .sdram_cas_o     (sdram_cas_o),
    .sdram_we_o      (sdram_we_o),
    .sdram_ba_o      (sdram_ba_o),
    .sdram_addr_o    (sdram_addr_o),
    .sdram_dqm_o     (sdram_dqm_o),
    .sdram_dq_o      (sdram_dq_o),
    .sdram_dq_oe_o   (sdram_dq_oe_o)
  );

  sdram_rd_path u_rd (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .state_i    (state),
    .sdram_dq_i (sdram_dq_i),
    .rdata_o    (rdata_o),
    .ack_o      (ack_o)
  );

endmodule

`default_nettype wire

//--- design/sdram_rd_path.sv
// rdata_o is only meaningful in the cycle ack_o is high for a read
`include "sdram_cfg.svh"
`default_nettype none

module sdram_rd_path
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire sdram_state_e        state_i,
  input  wire [`SDRAM_DATA_W-1:0]  sdram_dq_i,
  output logic [`SDRAM_DATA_W-1:0] rdata_o,
  output logic                     ack_o
);

  logic [`SDRAM_DATA_W-1:0] sample0_q;
  logic [`SDRAM_DATA_W-1:0] sample1_q;
  logic [1:0]               rd_q;

  // Two sampling stages off the pads
  always_ff @(posedge clk_i) begin
    sample0_q <= sdram_dq_i;
    sample1_q <= sample0_q;
  end

  // Read marker, tracks up to two reads in flight
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_q <= '0;
    end else begin
      rd_q <= {rd_q[0], (state_i == ST_READ)};
    end
  end

  // Write acks after WRITE1, read acks with the second sample
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else if ((state_i == ST_WRITE1) && !ack_o) begin
      ack_o <= 1'b1;
    end else begin
      ack_o <= rd_q[1];
    end
  end

  assign rdata_o = sample1_q;

endmodule

`default_nettype wire

//--- design/sdram_cmd_gen.sv
// All pin outputs are registered, so each command reaches the SDRAM one cycle after its state
`include "sdram_cfg.svh"
`default_nettype none

module sdram_cmd_gen
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire sdram_state_e        state_i,
  input  wire                      precharge_all_i,
  input  wire sdram_init_step_e    init_step_i,
  input  wire [`SDRAM_HADDR_W-1:0] addr_i,
  input  wire [`SDRAM_DQM_W-1:0]   wr_i,
  input  wire [`SDRAM_DATA_W-1:0]  wdata_i,
  output logic                     sdram_cke_o,
  output logic                     sdram_cs_o,
  output logic                     sdram_ras_o,
  output logic                     sdram_cas_o,
  output logic                     sdram_we_o,
  output logic [`SDRAM_BANK_W-1:0] sdram_ba_o,
  output logic [`SDRAM_ROW_W-1:0]  sdram_addr_o,
  output logic [`SDRAM_DQM_W-1:0]  sdram_dqm_o,
  output logic [`SDRAM_DATA_W-1:0] sdram_dq_o,
  output logic                     sdram_dq_oe_o
);

  sdram_cmd_u               cmd_q;
  logic [`SDRAM_ROW_W-1:0]  addr_q;
  logic [`SDRAM_BANK_W-1:0] bank_q;
  logic [`SDRAM_DQM_W-1:0]  dqm_q;
  logic [`SDRAM_DATA_W-1:0] data_q;
  logic                     cke_q;
  logic                     oe_q;

  logic [`SDRAM_ROW_W-1:0]  col_addr;
  logic [`SDRAM_ROW_W-1:0]  row_addr;
  logic [`SDRAM_BANK_W-1:0] bank;

  // Column zero-extended, so A10 (auto-precharge) stays low
  assign col_addr = {{(`SDRAM_ROW_W - `SDRAM_COL_W){1'b0}},
                     addr_i[`SDRAM_COL_LSB +: `SDRAM_COL_W]};
  assign row_addr = addr_i[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
  assign bank     = addr_i[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];

  // --------------------------------------------------
  // Command, address and mask registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_q.cmd <= CMD_NOP;
      addr_q    <= '0;
      bank_q    <= '0;
      dqm_q     <= '0;
      cke_q     <= 1'b0;
      oe_q      <= 1'b0;
    end else begin
      // NOP unless the state issues something
      cmd_q.cmd <= CMD_NOP;
      addr_q    <= '0;
      bank_q    <= '0;
      oe_q      <= 1'b0;
      case (state_i)
        ST_INIT: begin
          case (init_step_i)
            STEP_CKE: cke_q <= 1'b1;
            STEP_PRECHARGE_ALL: begin
              cmd_q.cmd              <= CMD_PRECHARGE;
              addr_q[`SDRAM_AP_BIT]  <= 1'b1;
            end
            STEP_REFRESH: cmd_q.cmd <= CMD_REFRESH;
            STEP_LOAD_MODE: begin
              cmd_q.cmd <= CMD_LOAD_MODE;
              addr_q    <= `SDRAM_MODE_REG;
            end
            default: cmd_q.cmd <= CMD_NOP;
          endcase
        end
        ST_ACTIVATE: begin
          cmd_q.cmd <= CMD_ACTIVE;
          addr_q    <= row_addr;
          bank_q    <= bank;
        end
        ST_PRECHARGE: begin
          cmd_q.cmd <= CMD_PRECHARGE;
          // All banks before refresh, else just the missed bank
          if (precharge_all_i) begin
            addr_q[`SDRAM_AP_BIT] <= 1'b1;
          end else begin
            bank_q <= bank;
          end
        end
        ST_REFRESH: cmd_q.cmd <= CMD_REFRESH;
        ST_READ: begin
          cmd_q.cmd <= CMD_READ;
          addr_q    <= col_addr;
          bank_q    <= bank;
          dqm_q     <= '0;
        end
        ST_WRITE0: begin
          cmd_q.cmd <= CMD_WRITE;
          addr_q    <= col_addr;
          bank_q    <= bank;
          // DQM high masks a byte
          dqm_q     <= ~wr_i;
          oe_q      <= 1'b1;
        end
        default: cmd_q.cmd <= CMD_NOP;
      endcase
    end
  end

  // Write data, used only while oe is high
  always_ff @(posedge clk_i) begin
    if (state_i == ST_WRITE0) begin
      data_q <= wdata_i;
    end
  end

  // --------------------------------------------------
  // Pin drive
  // --------------------------------------------------
  assign sdram_cke_o   = cke_q;
  assign sdram_cs_o    = cmd_q.pins.cs;
  assign sdram_ras_o   = cmd_q.pins.ras;
  assign sdram_cas_o   = cmd_q.pins.cas;
  assign sdram_we_o    = cmd_q.pins.we;
  assign sdram_ba_o    = bank_q;
  assign sdram_addr_o  = addr_q;
  assign sdram_dqm_o   = dqm_q;
  assign sdram_dq_o    = data_q;
  assign sdram_dq_oe_o = oe_q;

endmodule

`default_nettype wire

//--- design/sdram_seq_fsm.sv
// Single-word sequencer; delays are whole cycles and rd_i wins if both rd_i and wr_i are set
`include "sdram_cfg.svh"
`default_nettype none

module sdram_seq_fsm
  import sdram_pkg::*;
(
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    rd_i,
  input  wire [`SDRAM_DQM_W-1:0] wr_i,
  input  wire                    refresh_pending_i,
  input  wire                    row_hit_i,
  input  wire                    bank_open_i,
  input  wire                    any_open_i,
  output sdram_state_e           state_o,
  output logic                   precharge_all_o,
  output logic                   accept_o
);

  sdram_state_e state_q;
  sdram_state_e next_state;
  sdram_state_e target_q;
  sdram_state_e target_d;
  sdram_state_e resume_q;
  sdram_state_e access_state;

  logic [`SDRAM_DELAY_W-1:0] delay_q;
  logic [`SDRAM_DELAY_W-1:0] delay_d;
  logic                      req;

  assign req          = rd_i | (|wr_i);
  assign access_state = rd_i ? ST_READ : ST_WRITE0;

  // --------------------------------------------------
  // Next state and target
  // --------------------------------------------------
  always_comb begin
    next_state = state_q;
    target_d   = target_q;
    case (state_q)
      ST_INIT: begin
        // First refresh tick ends power-up
        if (refresh_pending_i) begin
          next_state = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (refresh_pending_i) begin
          // Close rows first, then refresh
          next_state = any_open_i ? ST_PRECHARGE : ST_REFRESH;
          target_d   = ST_REFRESH;
        end else if (req) begin
          if (row_hit_i) begin
            next_state = access_state;
          end else begin
            // Miss on an open bank closes it before activating
            next_state = bank_open_i ? ST_PRECHARGE : ST_ACTIVATE;
            target_d   = access_state;
          end
        end
      end
      ST_ACTIVATE:  next_state = target_q;
      ST_READ:      next_state = ST_READ_WAIT;
      ST_READ_WAIT: begin
        // Chain another hit read
        if (!refresh_pending_i && rd_i && row_hit_i) begin
          next_state = ST_READ;
        end else begin
          next_state = ST_IDLE;
        end
      end
      ST_WRITE0:    next_state = ST_WRITE1;
      ST_WRITE1: begin
        // Chain another hit write
        if (!refresh_pending_i && (|wr_i) && row_hit_i) begin
          next_state = ST_WRITE0;
        end else begin
          next_state = ST_IDLE;
        end
      end
      ST_PRECHARGE: begin
        next_state = (target_q == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
      end
      ST_REFRESH:   next_state = ST_IDLE;
      ST_DELAY:     next_state = resume_q;
      default:      next_state = ST_IDLE;
    endcase
  end

  // --------------------------------------------------
  // Wait cycles after each command
  // --------------------------------------------------
  always_comb begin
    case (state_q)
      ST_ACTIVATE:  delay_d = `SDRAM_TRCD_CYCLES;
      ST_PRECHARGE: delay_d = `SDRAM_TRP_CYCLES;
      ST_REFRESH:   delay_d = `SDRAM_TRFC_CYCLES;
      ST_DELAY:     delay_d = delay_q - 1'b1;
      default:      delay_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= ST_INIT;
      target_q <= ST_IDLE;
      resume_q <= ST_IDLE;
      delay_q  <= '0;
    end else begin
      target_q <= target_d;
      delay_q  <= delay_d;
      if (delay_d != '0) begin
        state_q <= ST_DELAY;
        // Remember where to go once the wait runs out
        if (state_q != ST_DELAY) begin
          resume_q <= next_state;
        end
      end else begin
        state_q <= next_state;
      end
    end
  end

  assign state_o         = state_q;
  assign precharge_all_o = (state_q == ST_PRECHARGE) && (target_q == ST_REFRESH);
  // Request taken in the cycle its command is issued
  assign accept_o        = (state_q == ST_READ) || (state_q == ST_WRITE0);

endmodule

`default_nettype wire

//--- design/sdram_bank_tracker.sv
// Tracks one open row per bank; addr_i must stay stable from IDLE until accept
`include "sdram_cfg.svh"
`default_nettype none

module sdram_bank_tracker
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire sdram_state_e        state_i,
  input  wire                      precharge_all_i,
  input  wire [`SDRAM_HADDR_W-1:0] addr_i,
  output logic                     row_hit_o,
  output logic                     bank_open_o,
  output logic                     any_open_o
);

  localparam int banks = 1 << `SDRAM_BANK_W;

  logic [banks-1:0]          open_q;
  logic [`SDRAM_ROW_W-1:0]   row_q [banks];
  logic [`SDRAM_BANK_W-1:0]  bank;
  logic [`SDRAM_ROW_W-1:0]   row;

  // Requested bank and row
  assign bank = addr_i[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
  assign row  = addr_i[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];

  // Open flags follow the ACTIVE and PRECHARGE commands
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      open_q <= '0;
    end else if (state_i == ST_ACTIVATE) begin
      open_q[bank] <= 1'b1;
    end else if (state_i == ST_PRECHARGE) begin
      // Refresh path closes every bank
      if (precharge_all_i) begin
        open_q <= '0;
      end else begin
        open_q[bank] <= 1'b0;
      end
    end
  end

  // Row latched when the bank is activated
  always_ff @(posedge clk_i) begin
    if (state_i == ST_ACTIVATE) begin
      row_q[bank] <= row;
    end
  end

  assign bank_open_o = open_q[bank];
  assign row_hit_o   = open_q[bank] && (row_q[bank] == row);
  assign any_open_o  = |open_q;

endmodule

`default_nettype wire

//--- design/sdram_refresh_timer.sv
// Counter first runs the power-up wait, then paces one auto-refresh per interval
`include "sdram_cfg.svh"
`default_nettype none

module sdram_refresh_timer
  import sdram_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire sdram_state_e state_i,
  output logic              refresh_pending_o,
  output sdram_init_step_e  init_step_o
);

  localparam int cnt_w = `SDRAM_REFRESH_CNT_W;
  // Extra margin so the init steps finish before the first refresh
  localparam logic [cnt_w-1:0] start_load = cnt_w'(`SDRAM_START_CYCLES + 100);
  localparam logic [cnt_w-1:0] period_load = cnt_w'(`SDRAM_REFRESH_CYCLES);

  logic [cnt_w-1:0] count_q;
  logic             count_zero;

  assign count_zero = (count_q == '0);

  // Down-counter, reloads on zero
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= start_load;
    end else if (count_zero) begin
      count_q <= period_load;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  // Pending until the sequencer reaches REFRESH
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      refresh_pending_o <= 1'b0;
    end else if (count_zero) begin
      refresh_pending_o <= 1'b1;
    end else if (state_i == ST_REFRESH) begin
      refresh_pending_o <= 1'b0;
    end
  end

  // Init step select, only while still in INIT
  always_comb begin
    init_step_o = STEP_NONE;
    if (state_i == ST_INIT) begin
      case (count_q)
        `SDRAM_INIT_CKE_AT:  init_step_o = STEP_CKE;
        `SDRAM_INIT_PRE_AT:  init_step_o = STEP_PRECHARGE_ALL;
        `SDRAM_INIT_REF0_AT: init_step_o = STEP_REFRESH;
        `SDRAM_INIT_REF1_AT: init_step_o = STEP_REFRESH;
        `SDRAM_INIT_MODE_AT: init_step_o = STEP_LOAD_MODE;
        default:             init_step_o = STEP_NONE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/sdram_pkg.sv
// Command encodings follow the standard SDR CS/RAS/CAS/WE truth table, all active low
`default_nettype none

package sdram_pkg;

  // --------------------------------------------------
  // Sequencer states
  // --------------------------------------------------
  typedef enum logic [3:0] {
    ST_INIT      = 4'd0,
    ST_DELAY     = 4'd1,
    ST_IDLE      = 4'd2,
    ST_ACTIVATE  = 4'd3,
    ST_READ      = 4'd4,
    ST_READ_WAIT = 4'd5,
    ST_WRITE0    = 4'd6,
    ST_WRITE1    = 4'd7,
    ST_PRECHARGE = 4'd8,
    ST_REFRESH   = 4'd9
  } sdram_state_e;

  // Power-up steps decoded from the start-up count
  typedef enum logic [2:0] {
    STEP_NONE,
    STEP_CKE,
    STEP_PRECHARGE_ALL,
    STEP_REFRESH,
    STEP_LOAD_MODE
  } sdram_init_step_e;

  // --------------------------------------------------
  // Command word, named or as pin levels
  // --------------------------------------------------
  typedef enum logic [3:0] {
    CMD_NOP       = 4'b0111,
    CMD_ACTIVE    = 4'b0011,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_LOAD_MODE = 4'b0000
  } sdram_cmd_e;

  typedef struct packed {
    logic cs;
    logic ras;
    logic cas;
    logic we;
  } sdram_pins_s;

  typedef union packed {
    sdram_cmd_e  cmd;
    sdram_pins_s pins;
  } sdram_cmd_u;

endpackage

`default_nettype wire

//--- design/sdram_cfg.svh
// Cycle counts assume a 50 MHz clock and 64 ms / 8192-row refresh; change them together
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// --------------------------------------------------
// Clock and geometry
// --------------------------------------------------
`define SDRAM_MHZ 50
// Word address span above the byte lanes (column + bank + row)
`define SDRAM_ADDR_W 24
`define SDRAM_COL_W 9
`define SDRAM_BANK_W 2
`define SDRAM_ROW_W 13
`define SDRAM_DATA_W 32
`define SDRAM_DQM_W 4

// Host byte address split, low to high
`define SDRAM_COL_LSB 2
`define SDRAM_BANK_LSB (`SDRAM_COL_LSB + `SDRAM_COL_W)
`define SDRAM_ROW_LSB (`SDRAM_BANK_LSB + `SDRAM_BANK_W)
`define SDRAM_HADDR_W (`SDRAM_ADDR_W + `SDRAM_COL_LSB)

// --------------------------------------------------
// Timing in clock cycles
// --------------------------------------------------
// 100 us power-up wait
`define SDRAM_START_CYCLES (100 * `SDRAM_MHZ)
// One row refreshed per interval, 64 ms over all rows
`define SDRAM_REFRESH_CYCLES ((64000 * `SDRAM_MHZ) / (1 << `SDRAM_ROW_W) - 1)
`define SDRAM_TRCD_CYCLES 1
`define SDRAM_TRP_CYCLES 1
`define SDRAM_TRFC_CYCLES 3
`define SDRAM_DELAY_W 4
`define SDRAM_REFRESH_CNT_W 17

// Write burst programmed, CAS 2, sequential, burst length 1
`define SDRAM_MODE_REG 13'b000_0_00_010_0_000
// A10 selects auto-precharge on READ/WRITE, all banks on PRECHARGE
`define SDRAM_AP_BIT 10

// Refresh counter values that trigger each power-up step
`define SDRAM_INIT_CKE_AT 50
`define SDRAM_INIT_PRE_AT 40
`define SDRAM_INIT_REF0_AT 30
`define SDRAM_INIT_REF1_AT 20
`define SDRAM_INIT_MODE_AT 10

`endif
